/* hdl/patch_macros.svh */
`ifndef PATCH_MACROS_SVH
`define PATCH_MACROS_SVH

// Stream record field widths
`define PATCH_NUM_W 20
`define WTSUM_W     20

// 12-bit LFSR gives 4095 records per block
`define LFSR_W      12

`define FIFO_DEPTH  16

`define AXIL_ADDR_W 5

`endif

/* hdl/patch_types_pkg.sv */
`include "patch_macros.svh"

package patch_types_pkg;

  typedef logic [`PATCH_NUM_W-1:0] patch_num_t;
  typedef logic [`WTSUM_W-1:0]     wtsum_t;

  // One stream record, also the FIFO payload
  typedef struct packed {
    patch_num_t patch_num;
    wtsum_t     wtsum;
  } patch_rec_t;

  localparam patch_num_t SOF_PATCH_NUM = '1; // Reserved start-of-frame number

  typedef enum logic [2:0] {
    INIT    = 3'd0,
    SOF     = 3'd1,
    SOF_GAP = 3'd2,
    BLOCK   = 3'd3,
    ERROR   = 3'd4
  } seq_state_t;

endpackage

/* hdl/patch_csr_pkg.sv */
`include "patch_macros.svh"

package patch_csr_pkg;

  localparam int AXIL_DATA_W = 32;

  // Byte offsets
  localparam logic [`AXIL_ADDR_W-1:0] CSR_CTRL      = 5'h00;
  localparam logic [`AXIL_ADDR_W-1:0] CSR_N_PATCH   = 5'h04;
  localparam logic [`AXIL_ADDR_W-1:0] CSR_THROTTLE  = 5'h08;
  localparam logic [`AXIL_ADDR_W-1:0] CSR_STATUS    = 5'h0c;
  localparam logic [`AXIL_ADDR_W-1:0] CSR_FRAME_CNT = 5'h10;
  localparam logic [`AXIL_ADDR_W-1:0] CSR_LAST_RECS = 5'h14;
  localparam logic [`AXIL_ADDR_W-1:0] CSR_LAST_SUM  = 5'h18;

  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int THROTTLE_W       = 8;
  localparam int STATUS_ERROR_BIT = 0;
  localparam int STATUS_STATE_LSB = 1;
  localparam int STATUS_STATE_MSB = 3;

endpackage

/* hdl/patch_sequencer.sv */
`timescale 1ns/1ps
`include "patch_macros.svh"

module patch_sequencer (
  input  logic                       clk_200,
  input  logic                       reset,
  input  logic                       enable,
  input  patch_types_pkg::patch_num_t n_patch,
  input  logic                       error_in,
  output logic                       rec_valid,
  input  logic                       rec_ready,
  output patch_types_pkg::patch_rec_t rec_data,
  output patch_types_pkg::seq_state_t seq_state
);
  import patch_types_pkg::*;

  localparam logic [`LFSR_W-1:0] LFSR_LAST = 1 << (`LFSR_W - 1); // Last value of a block
  localparam patch_num_t BLOCK_LEN = (1 << `LFSR_W) - 1;
  localparam logic [`PATCH_NUM_W:0] BLOCK_SPAN = 1 << `LFSR_W;

  seq_state_t              state;
  logic [`LFSR_W-1:0]      lfsr;
  logic [`LFSR_W-1:0]      lfsr_next;
  patch_num_t              offset;
  wtsum_t                  idx;       // Records issued in this block
  patch_num_t              cand;      // Candidate patch number
  logic                    in_range;
  logic                    advance;
  logic                    frame_done;

  assign lfsr_next = {lfsr[`LFSR_W-2:0], ~(lfsr[11] ^ lfsr[10] ^ lfsr[9] ^ lfsr[3])};
  assign cand      = offset + patch_num_t'(lfsr);
  assign in_range  = cand < n_patch;

  // Out-of-range candidates step without a FIFO write
  assign advance = !in_range || rec_ready;

  // Last block once the next window would reach past n_patch
  assign frame_done = ({1'b0, offset} + BLOCK_SPAN) > {1'b0, n_patch};

  assign rec_valid = (state == SOF) || ((state == BLOCK) && in_range);
  assign seq_state = state;

  always_comb begin
    if (state == SOF) begin
      rec_data.patch_num = SOF_PATCH_NUM;
      rec_data.wtsum     = wtsum_t'(1);
    end else begin
      rec_data.patch_num = cand;
      rec_data.wtsum     = idx;
    end
  end

  always_ff @(posedge clk_200) begin
    if (reset) begin
      state  <= INIT;
      lfsr   <= '0;
      offset <= '0;
      idx    <= '0;
    end else if (error_in) begin
      state <= ERROR; // Only reset leaves
    end else begin
      case (state)
        INIT: begin
          if (enable) begin
            state <= SOF;
          end
        end
        SOF: begin
          if (rec_ready) begin // Stall on full FIFO
            state <= SOF_GAP;
          end
        end
        SOF_GAP: begin
          lfsr   <= '0;
          offset <= '0;
          idx    <= '0;
          state  <= BLOCK;
        end
        BLOCK: begin
          if (advance) begin
            lfsr <= lfsr_next;
            if (in_range) begin
              idx <= idx + wtsum_t'(1);
            end
            if (lfsr == LFSR_LAST) begin
              lfsr <= '0;
              idx  <= '0;
              if (frame_done) begin
                state <= enable ? SOF : INIT;
              end else begin
                offset <= offset + BLOCK_LEN;
              end
            end
          end
        end
        ERROR: begin
          state <= ERROR;
        end
        default: begin
          state <= ERROR;
        end
      endcase
    end
  end

endmodule

/* hdl/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic     clk_200,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             wr_en;
  logic             rd_en;

  assign in_ready  = count != (PTR_W + 1)'(DEPTH); // Not full
  assign out_valid = count != '0;                  // Not empty
  assign out_data  = mem[rd_ptr];

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk_200) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk_200) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

endmodule

/* hdl/patch_tracker.sv */
`timescale 1ns/1ps

module patch_tracker (
  input  logic                        clk_200,
  input  logic                        reset,
  input  logic [7:0]                  throttle,
  input  logic                        out_valid,
  output logic                        out_ready,
  input  patch_types_pkg::patch_rec_t out_data,
  input  patch_types_pkg::patch_num_t n_patch,
  output logic                        range_error,
  output logic [31:0]                 frame_cnt,
  output logic [31:0]                 last_recs,
  output logic [31:0]                 last_sum
);
  import patch_types_pkg::*;

  logic [7:0]  thr_cnt;  // Cycles left before next accept
  logic        accept;
  logic        is_sof;
  logic [31:0] acc_recs; // Running frame
  logic [31:0] acc_sum;

  assign accept = out_valid && out_ready;
  assign is_sof = out_data.patch_num == SOF_PATCH_NUM;

  always_ff @(posedge clk_200) begin
    if (reset) begin
      thr_cnt   <= '0;
      out_ready <= 1'b0;
    end else if (accept) begin
      thr_cnt   <= throttle;
      out_ready <= throttle == 8'd0; // Full rate keeps ready high
    end else if (thr_cnt != 8'd0) begin
      thr_cnt   <= thr_cnt - 8'd1;
      out_ready <= thr_cnt == 8'd1;
    end else begin
      out_ready <= 1'b1;
    end
  end

  always_ff @(posedge clk_200) begin
    if (reset) begin
      acc_recs    <= '0;
      acc_sum     <= '0;
      frame_cnt   <= '0;
      last_recs   <= '0;
      last_sum    <= '0;
      range_error <= 1'b0;
    end else if (accept) begin
      if (is_sof) begin
        if (acc_recs != '0) begin // Close the previous frame
          last_recs <= acc_recs;
          last_sum  <= acc_sum;
          frame_cnt <= frame_cnt + 32'd1;
        end
        acc_recs <= '0;
        acc_sum  <= '0;
      end else begin
        acc_recs <= acc_recs + 32'd1;
        acc_sum  <= acc_sum + 32'(out_data.patch_num); // Wraps mod 2^32
        if (out_data.patch_num >= n_patch) begin
          range_error <= 1'b1; // Sticky
        end
      end
    end
  end

endmodule

/* hdl/patch_csr_axil.sv */
`timescale 1ns/1ps
`include "patch_macros.svh"

module patch_csr_axil (
  input  logic                                   clk_200,
  input  logic                                   reset,
  input  logic [`AXIL_ADDR_W-1:0]                awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [patch_csr_pkg::AXIL_DATA_W-1:0]   wdata,
  input  logic [patch_csr_pkg::AXIL_DATA_W/8-1:0] wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [`AXIL_ADDR_W-1:0]                araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [patch_csr_pkg::AXIL_DATA_W-1:0]   rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready,
  output logic                                   enable,
  output logic [`PATCH_NUM_W-1:0]                n_patch,
  output logic [patch_csr_pkg::THROTTLE_W-1:0]    throttle,
  input  patch_types_pkg::seq_state_t             seq_state,
  input  logic                                   range_error,
  input  logic [31:0]                            frame_cnt,
  input  logic [31:0]                            last_recs,
  input  logic [31:0]                            last_sum
);
  import patch_csr_pkg::*;

  logic                   wr_fire;
  logic                   rd_fire;
  logic [AXIL_DATA_W-1:0] wr_old;    // Current value at awaddr
  logic [AXIL_DATA_W-1:0] wr_merged; // After byte strobes
  logic [AXIL_DATA_W-1:0] rd_mux;

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;
  assign wready  = awready; // Address and data accepted together
  assign bresp   = 2'b00;
  assign rresp   = 2'b00;

  always_comb begin
    wr_old = '0;
    case (awaddr)
      CSR_CTRL:     wr_old[CTRL_ENABLE_BIT] = enable;
      CSR_N_PATCH:  wr_old[`PATCH_NUM_W-1:0] = n_patch;
      CSR_THROTTLE: wr_old[THROTTLE_W-1:0] = throttle;
      default:      wr_old = '0;
    endcase
    for (int b = 0; b < AXIL_DATA_W / 8; b++) begin
      wr_merged[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : wr_old[8*b +: 8];
    end
  end

  always_comb begin
    rd_mux = '0;
    case (araddr)
      CSR_CTRL:      rd_mux[CTRL_ENABLE_BIT] = enable;
      CSR_N_PATCH:   rd_mux[`PATCH_NUM_W-1:0] = n_patch;
      CSR_THROTTLE:  rd_mux[THROTTLE_W-1:0] = throttle;
      CSR_STATUS: begin
        rd_mux[STATUS_ERROR_BIT] = range_error;
        rd_mux[STATUS_STATE_MSB:STATUS_STATE_LSB] = seq_state;
      end
      CSR_FRAME_CNT: rd_mux = frame_cnt;
      CSR_LAST_RECS: rd_mux = last_recs;
      CSR_LAST_SUM:  rd_mux = last_sum;
      default:       rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_200) begin
    if (reset) begin
      awready  <= 1'b0;
      bvalid   <= 1'b0;
      enable   <= 1'b0;
      n_patch  <= '0;
      throttle <= '0;
    end else begin
      awready <= awvalid && wvalid && !awready && !bvalid; // One-cycle pulse
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (awaddr)
          CSR_CTRL:     enable <= wr_merged[CTRL_ENABLE_BIT];
          CSR_N_PATCH:  n_patch <= wr_merged[`PATCH_NUM_W-1:0];
          CSR_THROTTLE: throttle <= wr_merged[THROTTLE_W-1:0];
          default:      ; // Read-only or unmapped
        endcase
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_200) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_200) begin
    if (rd_fire) begin
      rdata <= rd_mux;
    end
  end

endmodule

/* hdl/patch_stream_top.sv */
`timescale 1ns/1ps
`include "patch_macros.svh"

module patch_stream_top (
  input  logic                                   clk_200,
  input  logic                                   reset,
  input  logic [`AXIL_ADDR_W-1:0]                awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [patch_csr_pkg::AXIL_DATA_W-1:0]   wdata,
  input  logic [patch_csr_pkg::AXIL_DATA_W/8-1:0] wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [`AXIL_ADDR_W-1:0]                araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [patch_csr_pkg::AXIL_DATA_W-1:0]   rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready
);
  import patch_types_pkg::*;
  import patch_csr_pkg::*;

  logic                  enable;
  patch_num_t            n_patch;
  logic [THROTTLE_W-1:0] throttle;
  seq_state_t            seq_state;
  logic                  range_error;
  logic [31:0]           frame_cnt;
  logic [31:0]           last_recs;
  logic [31:0]           last_sum;
  logic                  rec_valid;
  logic                  rec_ready;
  patch_rec_t            rec_data;
  logic                  out_valid;
  logic                  out_ready;
  patch_rec_t            out_data;

  patch_csr_axil csr0 (
    .clk_200, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .enable, .n_patch, .throttle,
    .seq_state, .range_error, .frame_cnt, .last_recs, .last_sum
  );

  patch_sequencer seq0 (
    .clk_200, .reset, .enable, .n_patch,
    .error_in (range_error), // Range error stops the stream
    .rec_valid, .rec_ready, .rec_data, .seq_state
  );

  stream_fifo #(.payload_t(patch_rec_t), .DEPTH(`FIFO_DEPTH)) fifo0 (
    .clk_200, .reset,
    .in_valid (rec_valid), .in_ready (rec_ready), .in_data (rec_data),
    .out_valid, .out_ready, .out_data
  );

  patch_tracker trk0 (
    .clk_200, .reset, .throttle,
    .out_valid, .out_ready, .out_data, .n_patch,
    .range_error, .frame_cnt, .last_recs, .last_sum
  );

endmodule

/* testbench/patch_stream_checker.sv */
`timescale 1ns/1ps

module patch_stream_checker #(
  parameter int DEPTH = 16
) (
  input logic                        clk_200,
  input logic                        reset,
  input logic                        rec_valid,
  input logic                        rec_ready,
  input logic                        out_valid,
  input logic                        out_ready,
  input patch_types_pkg::patch_rec_t out_data,
  input logic                        bvalid,
  input logic                        bready,
  input logic                        rvalid,
  input logic                        rready
);

  int occ;            // FIFO fill level seen from the handshakes
  int fail_count = 0; // Assertion failures so far

  always_ff @(posedge clk_200) begin
    if (reset) begin
      occ <= 0;
    end else begin
      occ <= occ + int'(rec_valid && rec_ready) - int'(out_valid && out_ready);
    end
  end

  a_no_write_when_full: assert property (@(posedge clk_200) disable iff (reset)
    !(rec_valid && rec_ready && occ >= DEPTH))
    else begin
      $error("FIFO accepted a write while full");
      fail_count++;
    end

  a_out_data_stable: assert property (@(posedge clk_200) disable iff (reset)
    (out_valid && !out_ready) |=> $stable(out_data))
    else begin
      $error("FIFO output changed while stalled");
      fail_count++;
    end

  a_bvalid_hold: assert property (@(posedge clk_200) disable iff (reset)
    (bvalid && !bready) |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  a_rvalid_hold: assert property (@(posedge clk_200) disable iff (reset)
    (rvalid && !rready) |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

endmodule

/* testbench/patch_stream_monitor.sv */
`timescale 1ns/1ps
`include "patch_macros.svh"

module patch_stream_monitor (
  input  logic                        clk_200,
  input  logic                        reset,
  input  logic                        out_valid,
  input  logic                        out_ready,
  input  patch_types_pkg::patch_rec_t out_data,
  input  logic [`AXIL_ADDR_W-1:0]     awaddr,
  input  logic                        awvalid,
  input  logic                        awready,
  input  logic [31:0]                 wdata,
  input  logic [3:0]                  wstrb,
  input  logic                        wvalid,
  input  logic                        wready,
  input  logic [1:0]                  bresp,
  input  logic                        bvalid,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_W-1:0]     araddr,
  input  logic                        arvalid,
  input  logic                        arready,
  input  logic [31:0]                 rdata,
  input  logic [1:0]                  rresp,
  input  logic                        rvalid,
  input  logic                        rready,
  output int                          err_count,
  output int                          blocks_done
);
  import patch_types_pkg::*;
  import patch_csr_pkg::*;

  logic [31:0]         reg_ctrl;
  logic [31:0]         reg_n;
  logic [31:0]         reg_thr;
  logic [31:0]         exp_frames;
  logic [31:0]         exp_last_recs;
  logic [31:0]         exp_last_sum;
  logic [31:0]         run_recs;
  logic [31:0]         run_sum;
  int                  frame_n;   // n_patch latched at SOF
  int                  m_off;
  logic [`LFSR_W-1:0]  m_lfsr;
  logic [31:0]         m_idx;
  bit                  pending_sof;
  logic [`AXIL_ADDR_W-1:0] rd_addr_q;
  logic [31:0]         rd_exp;
  logic [31:0]         rd_mask;

  function automatic logic [`LFSR_W-1:0] lfsr_step(input logic [`LFSR_W-1:0] v);
    return {v[`LFSR_W-2:0], ~(v[11] ^ v[10] ^ v[9] ^ v[3])};
  endfunction

  function automatic logic [31:0] merge_strobes(input logic [31:0] old_v,
                                                input logic [31:0] new_v,
                                                input logic [3:0]  strb);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = strb[b] ? new_v[8*b +: 8] : old_v[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] expected_read(input logic [`AXIL_ADDR_W-1:0] addr);
    case (addr)
      CSR_CTRL:      return reg_ctrl;
      CSR_N_PATCH:   return reg_n;
      CSR_THROTTLE:  return reg_thr;
      CSR_FRAME_CNT: return exp_frames;
      CSR_LAST_RECS: return exp_last_recs;
      CSR_LAST_SUM:  return exp_last_sum;
      default:       return 32'd0; // STATUS expects INIT and no error
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
    err_count++;
  endtask

  task automatic model_advance();
    if (m_lfsr == `LFSR_W'(1 << (`LFSR_W - 1))) begin // Block ends after 2048
      m_lfsr = '0;
      m_idx  = '0;
      blocks_done++;
      if (m_off + (1 << `LFSR_W) > frame_n) begin
        pending_sof = 1'b1;
      end else begin
        m_off = m_off + (1 << `LFSR_W) - 1;
      end
    end else begin
      m_lfsr = lfsr_step(m_lfsr);
    end
  endtask

  task automatic model_settle();
    while (!pending_sof && (m_off + int'(m_lfsr)) >= frame_n) begin
      model_advance(); // Out-of-range values never reach the FIFO
    end
  endtask

  task automatic check_record();
    logic [63:0] exp_sum;
    if (out_data.patch_num == SOF_PATCH_NUM) begin
      if (!pending_sof) begin
        $display("Error at %0t: start of frame arrived in the middle of a frame", $time);
        err_count++;
      end
      if (out_data.wtsum != wtsum_t'(1)) begin
        report_mismatch("sof wtsum", 32'd1, 32'(out_data.wtsum));
      end
      if (run_recs != 0) begin
        exp_sum = (64'(frame_n) * 64'(frame_n - 1)) / 2;
        if (run_recs != 32'(frame_n)) report_mismatch("frame records", frame_n, run_recs);
        if (run_sum != exp_sum[31:0]) report_mismatch("frame sum", exp_sum[31:0], run_sum);
        exp_last_recs = 32'(frame_n);
        exp_last_sum  = exp_sum[31:0];
        exp_frames    = exp_frames + 1;
      end
      frame_n     = int'(reg_n[`PATCH_NUM_W-1:0]);
      pending_sof = 1'b0;
      m_off       = 0;
      m_lfsr      = '0;
      m_idx       = '0;
      run_recs    = '0;
      run_sum     = '0;
      model_settle();
    end else if (pending_sof) begin
      $display("Error at %0t: data record arrived where a start of frame was due", $time);
      err_count++;
    end else begin
      if (32'(out_data.patch_num) != 32'(m_off + int'(m_lfsr))) begin
        report_mismatch("patch_num", 32'(m_off + int'(m_lfsr)), 32'(out_data.patch_num));
      end
      if (32'(out_data.wtsum) != m_idx) report_mismatch("wtsum", m_idx, 32'(out_data.wtsum));
      run_recs = run_recs + 1;
      run_sum  = run_sum + 32'(out_data.patch_num);
      m_idx    = m_idx + 1;
      model_advance();
      model_settle();
    end
  endtask

  always @(posedge clk_200) begin
    if (reset) begin
      reg_ctrl = '0;
      reg_n = '0;
      reg_thr = '0;
      exp_frames = '0;
      exp_last_recs = '0;
      exp_last_sum = '0;
      run_recs = '0;
      run_sum = '0;
      pending_sof = 1'b1;
      frame_n = 0;
    end else begin
      if (bvalid && bready && bresp != 2'b00) begin
        report_mismatch("bresp", 32'd0, 32'(bresp)); // Always OKAY
      end
      if (rvalid && rready) begin
        if (rresp != 2'b00) begin
          report_mismatch("rresp", 32'd0, 32'(rresp));
        end
        if ((rdata & rd_mask) != (rd_exp & rd_mask)) begin
          report_mismatch($sformatf("rdata@%0h", rd_addr_q), rd_exp & rd_mask, rdata & rd_mask);
        end
      end
      // Read data reflects values before this edge
      if (arvalid && arready) begin
        rd_addr_q = araddr;
        rd_exp    = expected_read(araddr);
        rd_mask   = 32'hffff_ffff;
        if (araddr == CSR_STATUS) begin
          rd_mask = (pending_sof && !reg_ctrl[0]) ? 32'h0000_000f : 32'h0000_0001;
        end
      end
      if (awvalid && awready && wvalid && wready) begin
        case (awaddr)
          CSR_CTRL:     reg_ctrl = merge_strobes(reg_ctrl, wdata, wstrb) & 32'h1;
          CSR_N_PATCH:  reg_n = merge_strobes(reg_n, wdata, wstrb) & 32'h000f_ffff;
          CSR_THROTTLE: reg_thr = merge_strobes(reg_thr, wdata, wstrb) & 32'h0000_00ff;
          default:      ; // Read-only offsets keep their value
        endcase
      end
      if (out_valid && out_ready) begin
        check_record();
      end
    end
  end

  initial begin
    err_count   = 0;
    blocks_done = 0;
  end

endmodule

/* testbench/tb_patch_stream.sv */
`timescale 1ns/1ps
`include "patch_macros.svh"

module tb_patch_stream;
  import patch_csr_pkg::*;

  localparam int MAX_THROTTLE = 7;
  localparam int WORST_RECS   = 12 * 5001; // About ten frames over all tests
  localparam int WATCHDOG_NS  = 2 * WORST_RECS * (MAX_THROTTLE + 1) * 20;

  logic                    clk_200;
  logic                    reset;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [31:0]             wdata;
  logic [3:0]              wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic                    arvalid;
  logic                    arready;
  logic [31:0]             rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;
  int                      mon_errs;
  int                      mon_blocks;
  logic [31:0]             lcg_state;
  int                      tests_run;
  int                      tests_failed;
  int                      extra_fails;

  patch_stream_top dut0 (.*);

  patch_stream_monitor mon0 (
    .clk_200, .reset,
    .out_valid (dut0.out_valid), .out_ready (dut0.out_ready), .out_data (dut0.out_data),
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .err_count (mon_errs), .blocks_done (mon_blocks)
  );

  bind patch_stream_top patch_stream_checker #(.DEPTH(`FIFO_DEPTH)) chk0 (
    .clk_200, .reset, .rec_valid, .rec_ready, .out_valid, .out_ready, .out_data,
    .bvalid, .bready, .rvalid, .rready
  );

  always #10 clk_200 = ~clk_200;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16; // Low bits are poor
  endfunction

  // Monitor mismatches, testbench checks and assertion failures
  function automatic int error_total();
    return mon_errs + extra_fails + dut0.chk0.fail_count;
  endfunction

  task automatic axi_write(input logic [`AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int delay;
    delay = int'(lcg_next() & 32'h3);
    @(posedge clk_200);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge clk_200); while (!awready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (delay) @(posedge clk_200);
    bready <= 1'b1;
    do @(posedge clk_200); while (!bvalid);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [`AXIL_ADDR_W-1:0] addr, output logic [31:0] data);
    int delay;
    delay = int'(lcg_next() & 32'h3);
    @(posedge clk_200);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk_200); while (!arready);
    arvalid <= 1'b0;
    repeat (delay) @(posedge clk_200);
    rready <= 1'b1;
    do @(posedge clk_200); while (!rvalid);
    data = rdata;
    rready <= 1'b0;
  endtask

  task automatic wait_frames(input logic [31:0] target);
    logic [31:0] cnt;
    do begin
      repeat (500) @(posedge clk_200);
      axi_read(CSR_FRAME_CNT, cnt);
    end while (cnt < target);
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    tests_run++;
    if (error_total() == errs_before) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, error_total() - errs_before);
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [31:0] frames;
    int          errs0;
    clk_200 = 1'b0;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lcg_state = 32'd33;
    tests_run = 0;
    tests_failed = 0;
    extra_fails = 0;
    repeat (16) @(posedge clk_200);
    reset <= 1'b0;

    errs0 = error_total();
    axi_write(CSR_N_PATCH, lcg_next() ^ (lcg_next() << 16), lcg_next() & 32'hf);
    axi_read(CSR_N_PATCH, v);
    axi_write(CSR_THROTTLE, lcg_next(), lcg_next() & 32'hf);
    axi_read(CSR_THROTTLE, v);
    axi_write(CSR_FRAME_CNT, 32'h0bad_cafe, 4'hf);
    axi_read(CSR_FRAME_CNT, v);
    axi_read(CSR_STATUS, v);
    report_test(1, "register readback", errs0);

    errs0 = error_total();
    axi_write(CSR_N_PATCH, 32'd5000, 4'hf);
    axi_write(CSR_THROTTLE, 32'd0, 4'hf);
    axi_write(CSR_CTRL, 32'd1, 4'hf);
    wait_frames(2);
    axi_read(CSR_LAST_RECS, v);
    axi_read(CSR_LAST_SUM, v);
    report_test(2, "frame statistics at full rate", errs0);

    errs0 = error_total();
    wait_frames(3);
    if (mon_blocks < 6) begin // Two blocks per 5000-patch frame
      $display("Error: fewer than two blocks per frame reached the tracker");
      extra_fails++;
    end
    report_test(3, "stream order", errs0);

    errs0 = error_total();
    frames = 32'd3;
    for (int k = 0; k < 2; k++) begin
      axi_write(CSR_THROTTLE, (lcg_next() % MAX_THROTTLE) + 1, 4'hf);
      frames = frames + 1;
      wait_frames(frames);
    end
    axi_read(CSR_LAST_RECS, v);
    axi_read(CSR_LAST_SUM, v);
    report_test(4, "back-pressure", errs0);

    errs0 = error_total();
    axi_read(CSR_FRAME_CNT, frames);
    wait_frames(frames + 1);
    repeat (3000) @(posedge clk_200); // Well inside the next frame
    axi_write(CSR_CTRL, 32'd0, 4'hf);
    do axi_read(CSR_STATUS, v); while (v[STATUS_STATE_MSB:STATUS_STATE_LSB] != 3'd0);
    do @(posedge clk_200); while (dut0.out_valid);
    axi_read(CSR_FRAME_CNT, frames);
    repeat (2000) @(posedge clk_200);
    axi_read(CSR_FRAME_CNT, v);
    if (v != frames) begin // Stopped stream closes no frame
      $display("FAILED at %0t: frame_cnt expected %0h actual %0h", $time, frames, v);
      extra_fails++;
    end
    axi_read(CSR_STATUS, v);
    report_test(5, "enable stop", errs0);

    errs0 = error_total();
    axi_write(CSR_N_PATCH, 32'd4096, 4'hf);
    axi_write(CSR_CTRL, 32'd1, 4'hf);
    wait_frames(frames + 2); // Closes the stopped frame, then one short frame
    axi_read(CSR_LAST_RECS, v);
    axi_read(CSR_LAST_SUM, v);
    report_test(6, "odd frame length", errs0);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/patch_types_pkg.sv
hdl/patch_csr_pkg.sv
hdl/patch_sequencer.sv
hdl/stream_fifo.sv
hdl/patch_tracker.sv
hdl/patch_csr_axil.sv
hdl/patch_stream_top.sv
testbench/patch_stream_checker.sv
testbench/patch_stream_monitor.sv
testbench/tb_patch_stream.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the patch stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_patch_stream \
  -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/Vtb_patch_stream" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
